// ==== verilog/cic_cfg_pkg.sv ====
/*
  Numeric limits and widths of the CIC interpolator.
  The RTL checks its parameters against these limits and the testbench
  stays inside them when it picks a configuration.
*/
package cic_cfg_pkg;

  // input samples are signed two's complement.
  localparam int c_inp_width = 8;

  // parameter limits of the filter.
  localparam int c_max_order  = 4; // number of comb and integrator stages.
  localparam int c_max_factor = 8; // interpolation factor R.
  localparam int c_max_delay  = 2; // differential delay M.

  // bit growth of one stage at the largest R*M.
  localparam int c_stage_growth = $clog2(c_max_factor * c_max_delay);

  // One width serves every allowed configuration.
  // With it the wrapped arithmetic inside the filter still gives an exact result.
  localparam int c_acc_width = c_inp_width + c_max_order * c_stage_growth;

  // slot index within one frame of R fast cycles.
  localparam int c_slot_width = $clog2(c_max_factor);

endpackage

// ==== verilog/cic_types_pkg.sv ====
/*
  Data types passed between the blocks of the CIC interpolator.
  Import next to the configuration package wherever these are needed.
*/
package cic_types_pkg;

  import cic_cfg_pkg::*;

  // one input sample from the low-rate source.
  typedef logic signed [c_inp_width-1:0] cic_in_t;

  // internal word, all sums wrap modulo 2**c_acc_width.
  typedef logic signed [c_acc_width-1:0] cic_acc_t;

  // frame timing from the rate generator.
  typedef struct packed {
    logic                    req;  // one-cycle sample request.
    logic [c_slot_width-1:0] slot; // position in the frame, 0 to R-1.
  } cic_tick_t;

  // comb chain result with its strobe.
  typedef struct packed {
    logic     valid; // high in the cycle after a new sample was taken.
    cic_acc_t data;
  } cic_stage_t;

endpackage

// ==== verilog/cic_rate_gen.sv ====
/*
  Frame timing of the interpolator. Counts fast cycles modulo the
  interpolation factor and requests a new input sample in the last
  slot of every frame.
*/
`timescale 1ns/10ps

module cic_rate_gen
  import cic_cfg_pkg::*, cic_types_pkg::*;
#(
  parameter int p_factor = 4
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_ena,
  output cic_tick_t o_tick
);

  localparam logic [c_slot_width-1:0] c_last_slot = c_slot_width'(p_factor - 1);

  logic [c_slot_width-1:0] slot_q;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      slot_q <= '0;
    else if (i_ena)
    begin
      if (slot_q == c_last_slot)
        slot_q <= '0; // frame wraps after R-1.
      else
        slot_q <= slot_q + 1'b1;
    end
  end

  // the request is only raised in an enabled cycle, so a hold suppresses it.
  assign o_tick.req  = i_ena && (slot_q == c_last_slot);
  assign o_tick.slot = slot_q;

  a_req_single: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tick.req |=> !o_tick.req)
    else $error("sample request held for more than one cycle.");

  a_factor_range: assert property (@(posedge i_clk)
    (p_factor >= 2) && (p_factor <= c_max_factor))
    else $error("interpolation factor out of range.");

endmodule

// ==== verilog/cic_comb_chain.sv ====
/*
  Low-rate comb section of the interpolator. Each stage subtracts the
  value it saw M samples earlier; the delay lines move only when a
  sample is requested, and the last difference is registered out.
*/
`timescale 1ns/10ps

module cic_comb_chain
  import cic_cfg_pkg::*, cic_types_pkg::*;
#(
  parameter int p_order = 3,
  parameter int p_delay = 1
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_ena,
  input  logic       i_req,
  input  cic_in_t    i_data,
  output cic_stage_t o_comb
);

  localparam int c_fill_width = c_acc_width - c_inp_width;

  cic_acc_t   dly_q [p_order][p_delay]; // index 0 holds the newest value.
  cic_acc_t   stage_in [p_order];
  cic_acc_t   diff_out;
  cic_stage_t comb_q;

  always_comb
  begin
    cic_acc_t run;
    run = {{c_fill_width{i_data[c_inp_width-1]}}, i_data}; // sign extension.
    for (int k = 0; k < p_order; k++)
    begin
      stage_in[k] = run;
      run = run - dly_q[k][p_delay-1]; // wraps at accumulator width.
    end
    diff_out = run;
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      for (int k = 0; k < p_order; k++)
      begin
        for (int j = 0; j < p_delay; j++)
          dly_q[k][j] <= '0;
      end
      comb_q <= '0;
    end
    else if (i_ena)
    begin
      comb_q.valid <= i_req;
      if (i_req)
      begin
        for (int k = 0; k < p_order; k++)
        begin
          dly_q[k][0] <= stage_in[k];
          for (int j = 1; j < p_delay; j++)
            dly_q[k][j] <= dly_q[k][j-1];
        end
        comb_q.data <= diff_out; // held until the next request.
      end
    end
  end

  assign o_comb = comb_q;

  a_param_range: assert property (@(posedge i_clk)
    (p_order >= 1) && (p_order <= c_max_order) &&
    (p_delay >= 1) && (p_delay <= c_max_delay))
    else $error("comb order or differential delay out of range.");

endmodule

// ==== verilog/cic_zero_stuff.sv ====
/*
  Upsampler of the interpolator. Places the held comb result into one
  slot of each frame, chosen by the phase parameter, and zeros into the
  remaining R-1 slots.
*/
`timescale 1ns/10ps

module cic_zero_stuff
  import cic_cfg_pkg::*, cic_types_pkg::*;
#(
  parameter int p_phase = 0
) (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_ena,
  input  logic [c_slot_width-1:0] i_slot,
  input  cic_stage_t              i_comb,
  output cic_acc_t                o_data
);

  localparam logic [c_slot_width-1:0] c_phase_slot = c_slot_width'(p_phase);

  cic_acc_t stuffed_q;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      stuffed_q <= '0;
    else if (i_ena)
    begin
      // only the phase slot passes the comb value.
      if (i_slot == c_phase_slot)
        stuffed_q <= i_comb.data;
      else
        stuffed_q <= '0;
    end
  end

  assign o_data = stuffed_q;

  // A fresh comb result always lands at the start of a frame.
  a_valid_slot: assert property (@(posedge i_clk) disable iff (i_rst)
    i_comb.valid |-> (i_slot == '0))
    else $error("comb result not aligned to the frame start.");

  a_zero_slots: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_data != '0) && $past(i_ena) |-> ($past(i_slot) == c_phase_slot))
    else $error("nonzero value outside the phase slot.");

endmodule

// ==== verilog/cic_integrator_chain.sv ====
/*
  Fast-rate integrator section of the interpolator. A cascade of
  running sums fed by the zero-stuffed stream; the sum of the last stage
  is the registered filter output.
*/
`timescale 1ns/10ps

module cic_integrator_chain
  import cic_types_pkg::*;
#(
  parameter int p_order = 3
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_ena,
  input  cic_acc_t i_data,
  output cic_acc_t o_data
);

  cic_acc_t acc_q [p_order]; // one accumulator per stage.
  cic_acc_t sum [p_order];

  // each stage adds the new sum of the stage before it to its own register.
  always_comb
  begin
    cic_acc_t run;
    run = i_data;
    for (int k = 0; k < p_order; k++)
    begin
      run = run + acc_q[k]; // overflow wraps and cancels in the final result.
      sum[k] = run;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      for (int k = 0; k < p_order; k++)
        acc_q[k] <= '0;
    end
    else if (i_ena)
    begin
      for (int k = 0; k < p_order; k++)
        acc_q[k] <= sum[k];
    end
  end

  // The last accumulator doubles as the output register.
  // o_data therefore follows i_data one edge later.
  assign o_data = acc_q[p_order-1];

endmodule

// ==== verilog/cic_interp_top.sv ====
/*
  CIC interpolation filter. Requests one signed sample every R fast
  cycles and delivers one filtered sample per enabled cycle. i_ena low
  freezes the whole filter.
*/
`timescale 1ns/10ps

module cic_interp_top
  import cic_types_pkg::*;
#(
  parameter int p_order  = 3,
  parameter int p_factor = 4,
  parameter int p_delay  = 1,
  parameter int p_phase  = 0
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_ena,
  input  cic_in_t  i_data,
  output logic     o_sample_req,
  output cic_acc_t o_data
);

  cic_tick_t  tick;
  cic_stage_t comb_out;
  cic_acc_t   stuffed;

  cic_rate_gen #(
    .p_factor (p_factor)
  ) cic_rate_gen_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_ena  (i_ena),
    .o_tick (tick)
  );

  // the source answers each request in the same cycle.
  assign o_sample_req = tick.req;

  cic_comb_chain #(
    .p_order (p_order),
    .p_delay (p_delay)
  ) cic_comb_chain_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_ena  (i_ena),
    .i_req  (tick.req),
    .i_data (i_data),
    .o_comb (comb_out)
  );

  cic_zero_stuff #(
    .p_phase (p_phase)
  ) cic_zero_stuff_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_ena  (i_ena),
    .i_slot (tick.slot),
    .i_comb (comb_out),
    .o_data (stuffed)
  );

  cic_integrator_chain #(
    .p_order (p_order)
  ) cic_integrator_chain_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_ena  (i_ena),
    .i_data (stuffed),
    .o_data (o_data)
  );

endmodule

// ==== testbench/cic_interp_tb.sv ====
/*
  Testbench of the CIC interpolator. Drives reset, an impulse, a DC step,
  random full-scale samples and random holds, and compares every enabled
  output against a reference model of the filter.
*/
`timescale 1ns/10ps

module cic_interp_tb
  import cic_cfg_pkg::*, cic_types_pkg::*;
();

  localparam int c_order  = 3;
  localparam int c_factor = 4;
  localparam int c_delay  = 1;
  localparam int c_phase  = 0;

  localparam int c_hist_len      = c_order * c_delay + 1;
  localparam int c_impulse_zeros = c_order * c_delay + 4;
  localparam int c_dc_frames     = 30;
  localparam int c_rand_frames   = 200;
  localparam int c_hold_frames   = 100;
  localparam int c_drain_frames  = c_order * c_delay + 2;
  localparam int c_hold_chance   = 40; // out of 128 cycles held.
  localparam int c_dc_gain       = 100 * (c_factor * c_delay) ** (c_order - 1);

  localparam int c_total_samples = 1 + c_impulse_zeros + c_dc_frames + c_rand_frames +
                                   c_hold_frames + c_drain_frames;
  localparam int c_watchdog_ns   = c_total_samples * c_factor * 40 * 2 + 4000;

  logic     i_clk;
  logic     i_rst;
  logic     i_ena;
  cic_in_t  i_data;
  logic     o_sample_req;
  cic_acc_t o_data;

  int       seed;
  logic     model_ready;
  logic     exp_req;
  cic_acc_t exp_data;
  int       ena_count;

  // the reference model advances only on enabled edges.
  cic_acc_t hist [c_hist_len]; // low-rate input history with the newest sample first.
  cic_acc_t integ [c_order];
  cic_acc_t pend_val [$];      // comb results waiting for their slot.
  int       pend_due [$];
  int       edge_n;

  cic_interp_top #(
    .p_order  (c_order),
    .p_factor (c_factor),
    .p_delay  (c_delay),
    .p_phase  (c_phase)
  ) cic_interp_top_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ena        (i_ena),
    .i_data       (i_data),
    .o_sample_req (o_sample_req),
    .o_data       (o_data)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic fail_run();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error.");
  endtask

  task automatic check_data(input cic_acc_t exp, input cic_acc_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED o_data expected %h got %h", exp, act);
      fail_run();
    end
  endtask

  task automatic check_req(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED o_sample_req expected %h got %h", exp, act);
      $display("the sample request came at the wrong time.");
      fail_run();
    end
  endtask

  function automatic void model_reset();
    foreach (hist[k])
      hist[k] = '0;
    foreach (integ[k])
      integ[k] = '0;
    pend_val.delete();
    pend_due.delete();
    edge_n = 0;
  endfunction

  // expected o_data after one enabled edge. take marks the edge that ends a request cycle.
  function automatic cic_acc_t cic_model(input logic take, input cic_in_t x);
    cic_acc_t comb;
    cic_acc_t v;
    int       coef;
    edge_n++;
    if (take)
    begin
      for (int k = c_hist_len - 1; k > 0; k--)
        hist[k] = hist[k-1];
      hist[0] = cic_acc_t'(x);
      // N cascaded differences equal a binomial sum over the history.
      comb = '0;
      coef = 1;
      for (int k = 0; k <= c_order; k++)
      begin
        if (k % 2 == 0)
          comb = comb + cic_acc_t'(coef) * hist[k*c_delay];
        else
          comb = comb - cic_acc_t'(coef) * hist[k*c_delay];
        coef = coef * (c_order - k) / (k + 1);
      end
      pend_val.push_back(comb);
      pend_due.push_back(edge_n + 2 + c_phase); // first output of the frame.
    end
    v = '0;
    if (pend_due.size() > 0)
    begin
      if (pend_due[0] == edge_n)
      begin
        v = pend_val.pop_front();
        void'(pend_due.pop_front());
      end
    end
    integ[0] = integ[0] + v;
    for (int k = 1; k < c_order; k++)
      integ[k] = integ[k] + integ[k-1];
    return integ[c_order-1];
  endfunction

  // request and data are sampled at the rising edge, o_data half a cycle later.
  always
  begin
    @(posedge i_clk);
    if (i_rst)
    begin
      model_reset();
      exp_data    = '0;
      ena_count   = 0;
      model_ready = 1'b1;
    end
    else if (i_ena)
    begin
      exp_req = (ena_count % c_factor) == (c_factor - 1);
      check_req(exp_req, o_sample_req);
      exp_data = cic_model(exp_req, i_data);
      ena_count++;
    end
    else
      check_req(1'b0, o_sample_req); // a hold suppresses requests.
    @(negedge i_clk);
    if (model_ready)
      check_data(exp_data, o_data);
  end

  // presents one sample until the filter takes it, with random holds.
  task automatic feed_sample(input cic_in_t value, input int hold_chance);
    int   r;
    logic taken;
    i_data = value;
    taken  = 1'b0;
    while (!taken)
    begin
      r     = $random(seed);
      i_ena = (r & 127) >= hold_chance;
      @(posedge i_clk);
      taken = o_sample_req;
      @(negedge i_clk);
    end
  endtask

  function automatic cic_in_t random_extreme();
    int r;
    r = $random(seed);
    case (r & 3)
      0:       return cic_in_t'(-(2 ** (c_inp_width - 1)));
      1:       return cic_in_t'(2 ** (c_inp_width - 1) - 1);
      default: return cic_in_t'(r >>> 8);
    endcase
  endfunction

  task automatic check_dc_gain();
    for (int k = 0; k < c_factor; k++)
    begin
      check_data(cic_acc_t'(c_dc_gain), o_data);
      @(negedge i_clk);
    end
  endtask

  initial
  begin
    seed        = 32'hcac094e4;
    model_ready = 1'b0;
    exp_req     = 1'b0;
    i_rst       = 1'b1;
    i_ena       = 1'b0;
    i_data      = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    $display("impulse response");
    feed_sample(cic_in_t'(1), 0);
    repeat (c_impulse_zeros) feed_sample('0, 0);
    $display("dc step");
    repeat (c_dc_frames) feed_sample(cic_in_t'(100), 0);
    check_dc_gain();
    $display("random full-scale samples");
    repeat (c_rand_frames) feed_sample(random_extreme(), 0);
    $display("random holds");
    repeat (c_hold_frames) feed_sample(random_extreme(), c_hold_chance);
    repeat (c_drain_frames) feed_sample('0, 0);
    repeat (2 * c_factor) @(negedge i_clk);
    $display("All tests passed");
    $finish;
  end

  initial
  begin
    #(c_watchdog_ns);
    $display("the watchdog expired before the test sequence finished.");
    $display("Some tests failed");
    $fatal(1, "timeout.");
  end

endmodule

// ==== cic_interp.f ====
verilog/cic_cfg_pkg.sv
verilog/cic_types_pkg.sv
verilog/cic_rate_gen.sv
verilog/cic_comb_chain.sv
verilog/cic_zero_stuff.sv
verilog/cic_integrator_chain.sv
verilog/cic_interp_top.sv
testbench/cic_interp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CIC interpolator testbench with Verilator and runs it.
# The exit status is that of the simulation and is nonzero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cic_interp_tb \
  -f cic_interp.f \
  -o cic_interp_sim \
  && ./obj_dir/cic_interp_sim \
  || exit 1
